// File: common/seg_display_pkg.sv
//--------------------------------------------------------------------------
// seven-segment display package
// register addresses, scanner config and panel drive types
//--------------------------------------------------------------------------
package seg_display_pkg;

	// eight digits, one per nibble of the 32-bit value
	localparam int NUM_DIGITS = 8;

	// one glyph is 7 segments plus decimal point
	localparam int GLYPH_W = 8;

	// register addresses, used as the host opcodes
	typedef enum logic [1:0] {
		ADDR_VALUE    = 2'd0,
		ADDR_DIGIT_EN = 2'd1,
		ADDR_DP_EN    = 2'd2
	} reg_addr_e;

	// what the scanner needs from the register block
	typedef struct packed {
		// hex value, nibble 7 on the leftmost digit
		logic [31:0]           value;
		// per-digit enable, 1 = lit
		logic [NUM_DIGITS-1:0] digit_en;
		// per-digit decimal point, 1 = on
		logic [NUM_DIGITS-1:0] dp_en;
	} disp_cfg_t;

	// panel pins, both active low
	typedef struct packed {
		// bit 7 dp, bits 6..0 segments g..a
		logic [GLYPH_W-1:0]    seg;
		// one select per digit
		logic [NUM_DIGITS-1:0] sel;
	} seg_drive_t;

endpackage

// File: seg_display/scan_tick.sv
//--------------------------------------------------------------------------
// scan tick generator
// one-cycle pulse every CLK_FREQ / SCAN_FREQ clocks
//--------------------------------------------------------------------------
module scan_tick #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int SCAN_FREQ = 1000
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	output logic scan_tick_pulse
);

	// division ratio, at least 2
	localparam int DIV   = CLK_FREQ / SCAN_FREQ;
	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CNT_W-1:0] cnt;
	logic             wrap;

	// last count before rollover
	assign wrap = (cnt == CNT_W'(DIV - 1));

	// free running divider, 0 .. DIV-1
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cnt <= '0;
		end else if (wrap) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// registered pulse, first one DIV cycles after reset release
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			scan_tick_pulse <= 1'b0;
		end else begin
			scan_tick_pulse <= wrap;
		end
	end

endmodule

// File: seg_display/seg_scanner.sv
//--------------------------------------------------------------------------
// digit scanner for an eight-digit common-anode panel
// steps one digit per tick, looks up the hex glyph, registers the pins
//--------------------------------------------------------------------------
module seg_scanner (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  logic                       scan_tick_pulse,
	input  seg_display_pkg::disp_cfg_t cfg,
	output seg_display_pkg::seg_drive_t drive
);

	import seg_display_pkg::*;

	localparam int IDX_W = $clog2(NUM_DIGITS);

	// common-anode hex font, entry n at bits [8n+7:8n]
	// 0 C0, 1 F9, ... E 84, F 8E
	localparam logic [16*GLYPH_W-1:0] FONT = {
		8'h8E, 8'h84, 8'hA1, 8'hA7,
		8'h83, 8'h88, 8'h90, 8'h80,
		8'hF8, 8'h82, 8'h92, 8'h99,
		8'hB0, 8'hA4, 8'hF9, 8'hC0
	};

	// digit shown on the next tick
	logic [IDX_W-1:0]      idx;
	// nibble position for that digit
	logic [IDX_W-1:0]      nib_idx;
	logic [3:0]            nibble;
	logic [GLYPH_W-1:0]    glyph;
	logic [NUM_DIGITS-1:0] one_hot;
	logic                  dp_on;
	seg_drive_t            drive_nxt;

	// digit index, wraps naturally at 8
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			idx <= '0;
		end else if (scan_tick_pulse) begin
			idx <= idx + 1'b1;
		end
	end

	// leftmost digit carries the top nibble
	assign nib_idx = IDX_W'(NUM_DIGITS - 1) - idx;
	assign nibble  = cfg.value[{nib_idx, 2'b00} +: 4];

	// font lookup
	assign glyph = FONT[{nibble, 3'b000} +: GLYPH_W];

	// decimal point for this digit
	assign dp_on = cfg.dp_en[idx];

	// select only the current digit, and only if enabled
	assign one_hot = NUM_DIGITS'(1) << idx;

	always_comb begin
		drive_nxt.seg    = glyph;
		// dp segment is bit 7, active low
		drive_nxt.seg[7] = glyph[7] & ~dp_on;
		drive_nxt.sel    = ~(one_hot & cfg.digit_en);
	end

	// pin register
	// blank after reset, loads only on a tick so config
	// changes never show mid-digit
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			drive <= '1;
		end else if (scan_tick_pulse) begin
			drive <= drive_nxt;
		end
	end

endmodule

// File: hdl/disp_regs.sv
//--------------------------------------------------------------------------
// display register block
// value, digit enable and decimal point registers with strobed access
//--------------------------------------------------------------------------
module disp_regs (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  logic                       reg_wr,
	input  logic                       reg_rd,
	input  seg_display_pkg::reg_addr_e reg_addr,
	input  logic [31:0]                reg_wdata,
	output logic [31:0]                reg_rdata,
	output logic                       rd_vld,
	output seg_display_pkg::disp_cfg_t cfg
);

	import seg_display_pkg::*;

	// all three registers live in one struct
	disp_cfg_t   cfg_q;
	// read mux, old contents when write and read collide
	logic [31:0] rd_mux;

	// register writes
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			// blank value, all digits on, no dp
			cfg_q.value    <= '0;
			cfg_q.digit_en <= '1;
			cfg_q.dp_en    <= '0;
		end else if (reg_wr) begin
			case (reg_addr)
				ADDR_VALUE:    cfg_q.value    <= reg_wdata;
				// mask registers keep the low byte
				ADDR_DIGIT_EN: cfg_q.digit_en <= reg_wdata[NUM_DIGITS-1:0];
				ADDR_DP_EN:    cfg_q.dp_en    <= reg_wdata[NUM_DIGITS-1:0];
				default:       cfg_q          <= cfg_q;
			endcase
		end
	end

	// readback, zero extended
	always_comb begin
		case (reg_addr)
			ADDR_VALUE:    rd_mux = cfg_q.value;
			ADDR_DIGIT_EN: rd_mux = {{(32-NUM_DIGITS){1'b0}}, cfg_q.digit_en};
			ADDR_DP_EN:    rd_mux = {{(32-NUM_DIGITS){1'b0}}, cfg_q.dp_en};
			// unmapped address reads zero
			default:       rd_mux = '0;
		endcase
	end

	// read data, one cycle after the strobe
	always_ff @(posedge sys_clk) begin
		if (reg_rd) begin
			reg_rdata <= rd_mux;
		end
	end

	// valid pulse alongside the data
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			rd_vld <= 1'b0;
		end else begin
			rd_vld <= reg_rd;
		end
	end

	// scanner sees the registers directly
	assign cfg = cfg_q;

endmodule

// File: hdl/seg_display_top.sv
//--------------------------------------------------------------------------
// seven-segment display controller top
// register block, scan tick and digit scanner
//--------------------------------------------------------------------------
module seg_display_top #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int SCAN_FREQ = 1000
) (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  logic                       reg_wr,
	input  logic                       reg_rd,
	input  seg_display_pkg::reg_addr_e reg_addr,
	input  logic [31:0]                reg_wdata,
	output logic [31:0]                reg_rdata,
	output logic                       rd_vld,
	output logic [7:0]                 seg_out,
	output logic [7:0]                 sel_out
);

	import seg_display_pkg::*;

	disp_cfg_t  cfg;
	seg_drive_t drive;
	logic       scan_tick_pulse;

	// host registers
	disp_regs disp_regs_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.reg_wr    (reg_wr),
		.reg_rd    (reg_rd),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.rd_vld    (rd_vld),
		.cfg       (cfg)
	);

	// scan rate divider
	scan_tick #(
		.CLK_FREQ  (CLK_FREQ),
		.SCAN_FREQ (SCAN_FREQ)
	) scan_tick_i (
		.sys_clk         (sys_clk),
		.sys_rst_n       (sys_rst_n),
		.scan_tick_pulse (scan_tick_pulse)
	);

	// digit scan and glyph lookup
	seg_scanner seg_scanner_i (
		.sys_clk         (sys_clk),
		.sys_rst_n       (sys_rst_n),
		.scan_tick_pulse (scan_tick_pulse),
		.cfg             (cfg),
		.drive           (drive)
	);

	// panel pins
	assign seg_out = drive.seg;
	assign sel_out = drive.sel;

endmodule

// File: sim/seg_display_assertions.sv
//--------------------------------------------------------------------------
// scanner output assertions
// one select at a time, blank after reset, pins move only on a tick
//--------------------------------------------------------------------------
module seg_display_assertions (
	input logic                        sys_clk,
	input logic                        sys_rst_n,
	input logic                        scan_tick_pulse,
	input seg_display_pkg::seg_drive_t drive
);

	// at most one digit driven at a time
	sel_one_low: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		$countones(~drive.sel) <= 1
	) else $error("more than one digit select low, sel=%b", drive.sel);

	// reset blanks the whole panel
	blank_after_reset: assert property (
		@(posedge sys_clk)
		!sys_rst_n |=> (drive == '1)
	) else $error("panel not blank after reset, drive=%h", drive);

	// pins hold between ticks
	hold_between_ticks: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		!$stable(drive) |-> $past(scan_tick_pulse)
	) else $error("panel drive changed without a scan tick, drive=%h", drive);

endmodule

bind seg_scanner seg_display_assertions seg_display_assertions_i (
	.sys_clk         (sys_clk),
	.sys_rst_n       (sys_rst_n),
	.scan_tick_pulse (scan_tick_pulse),
	.drive           (drive)
);

// File: sim/tb_seg_display.sv
//--------------------------------------------------------------------------
// testbench for the seven-segment display controller
// register readback, glyph scan against the cases file, mid-scan reset
//--------------------------------------------------------------------------
module tb_seg_display;

	import seg_display_pkg::*;

	localparam int CLK_FREQ   = 4000;
	localparam int SCAN_FREQ  = 1000;
	// clocks per scan tick
	localparam int DIV        = CLK_FREQ / SCAN_FREQ;
	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 3;
	// value, digit_en, dp_en, then one glyph code per digit
	localparam int CASE_WORDS = 3 + NUM_DIGITS;
	localparam int NUM_CASES  = 28;
	localparam int TIMEOUT    = NUM_CASES * 16 * DIV * CLK_PERIOD + 2000;

	logic        sys_clk = 1'b0;
	logic        sys_rst_n;
	logic        reg_wr;
	logic        reg_rd;
	reg_addr_e   reg_addr;
	logic [31:0] reg_wdata;
	logic [31:0] reg_rdata;
	logic        rd_vld;
	logic [7:0]  seg_out;
	logic [7:0]  sel_out;

	logic [31:0] case_mem [0:NUM_CASES*CASE_WORDS-1];
	logic [31:0] lfsr_state = 32'h61f8;
	// rising edges seen since reset release
	int          cyc = 0;

	seg_display_top #(
		.CLK_FREQ  (CLK_FREQ),
		.SCAN_FREQ (SCAN_FREQ)
	) seg_display_top_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.reg_wr    (reg_wr),
		.reg_rd    (reg_rd),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.rd_vld    (rd_vld),
		.seg_out   (seg_out),
		.sel_out   (sel_out)
	);

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	// reference cycle count, the panel reloads at cycle k*DIV + 1
	always @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	// 32-bit fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit taken
	function automatic logic [31:0] next_rand_word();
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			w = {w[30:0], lfsr_state[0]};
		end
		return w;
	endfunction

	function automatic seg_drive_t panel_drive();
		seg_drive_t d;
		d.seg = seg_out;
		d.sel = sel_out;
		return d;
	endfunction

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_glyph(input string name, input seg_drive_t exp, input seg_drive_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_rdata(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (act !== exp) begin
			$display("Fail %s: expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_sel(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("Fail %s: expected %b actual %b", name, exp, act);
			abort_run();
		end
	endtask

	// entered and left on a falling edge
	task automatic hold_reset();
		sys_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst_n = 1'b1;
	endtask

	task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
		@(negedge sys_clk);
		reg_wr    = 1'b1;
		reg_addr  = addr;
		reg_wdata = data;
		@(negedge sys_clk);
		reg_wr = 1'b0;
	endtask

	// data and rd_vld one cycle after the strobe, rd_vld gone the cycle after
	task automatic check_read_response(input logic [31:0] exp, input string name);
		if (rd_vld !== 1'b1) begin
			$display("rd_vld did not pulse one cycle after the read strobe in %s", name);
			abort_run();
		end
		check_rdata(name, exp, reg_rdata);
		@(negedge sys_clk);
		if (rd_vld !== 1'b0) begin
			$display("rd_vld stayed high for more than one cycle in %s", name);
			abort_run();
		end
	endtask

	task automatic read_and_check(input reg_addr_e addr, input logic [31:0] exp,
			input string name);
		@(negedge sys_clk);
		reg_rd   = 1'b1;
		reg_addr = addr;
		@(negedge sys_clk);
		reg_rd = 1'b0;
		check_read_response(exp, name);
	endtask

	// falling edge just after the next panel reload, and the digit it shows
	task automatic wait_window(output int digit);
		int n;
		n = 0;
		do begin
			@(negedge sys_clk);
			n++;
			if (n > 2 * DIV + 2) begin
				$display("no scan window found within %0d cycles", n);
				abort_run();
			end
		end while (!(cyc > DIV && (cyc - 1) % DIV == 0));
		digit = ((cyc - 1) / DIV - 1) % NUM_DIGITS;
	endtask

	// panel stays dark until the first tick after reset
	task automatic check_reset_blank(input string name);
		seg_drive_t blank;
		blank = '1;
		repeat (DIV) begin
			@(negedge sys_clk);
			check_glyph(name, blank, panel_drive());
		end
	endtask

	task automatic check_cases_loaded();
		for (int c = 0; c < NUM_CASES; c++) begin
			for (int k = 1; k < CASE_WORDS; k++) begin
				if (case_mem[c * CASE_WORDS + k][31:8] != 24'h0) begin
					$display("cases file missing or malformed at case %0d", c);
					abort_run();
				end
			end
		end
	endtask

	task automatic test_readback();
		reg_addr_e   addrs [3];
		logic [31:0] data;
		logic [31:0] exp;
		logic [31:0] old_value;
		addrs = '{ADDR_VALUE, ADDR_DIGIT_EN, ADDR_DP_EN};
		old_value = '0;
		foreach (addrs[i]) begin
			data = next_rand_word();
			write_reg(addrs[i], data);
			// mask registers hold the low byte only
			exp = (addrs[i] == ADDR_VALUE) ? data : {24'h0, data[7:0]};
			if (addrs[i] == ADDR_VALUE) begin
				old_value = data;
			end
			read_and_check(addrs[i], exp, $sformatf("readback %s", addrs[i].name()));
		end
		// write and read together, read sees the old value
		data = next_rand_word();
		@(negedge sys_clk);
		reg_wr    = 1'b1;
		reg_rd    = 1'b1;
		reg_addr  = ADDR_VALUE;
		reg_wdata = data;
		@(negedge sys_clk);
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		check_read_response(old_value, "collision old value");
		read_and_check(ADDR_VALUE, data, "collision new value");
	endtask

	task automatic run_case(input int c);
		int         base;
		int         d;
		logic [7:0] en;
		logic [7:0] dp;
		logic [7:0] prev_sel;
		seg_drive_t exp;
		string      name;
		base = c * CASE_WORDS;
		en = case_mem[base + 1][7:0];
		dp = case_mem[base + 2][7:0];
		write_reg(ADDR_VALUE, case_mem[base]);
		write_reg(ADDR_DIGIT_EN, {24'h0, en});
		write_reg(ADDR_DP_EN, {24'h0, dp});
		// first window may still mix old and new settings
		wait_window(d);
		wait_window(d);
		prev_sel = 8'hFF;
		for (int w = 0; w < NUM_DIGITS; w++) begin
			wait_window(d);
			name = $sformatf("case %0d digit %0d", c, d);
			if (en[d]) begin
				exp.seg = case_mem[base + 3 + d][7:0];
				exp.sel = ~(8'(1) << d);
				check_glyph(name, exp, panel_drive());
			end else begin
				// disabled digit never selected
				check_sel(name, 8'hFF, sel_out);
			end
			// low select bit walks up one position per window
			if (en == 8'hFF && w > 0) begin
				check_sel({name, " order"}, {prev_sel[6:0], prev_sel[7]}, sel_out);
			end
			prev_sel = sel_out;
		end
	endtask

	task automatic test_mid_reset();
		int         d;
		seg_drive_t exp;
		// move every register off its reset value first
		write_reg(ADDR_VALUE, 32'h89AB_CDEF);
		write_reg(ADDR_DIGIT_EN, 32'h5A);
		write_reg(ADDR_DP_EN, 32'hA5);
		// land between two ticks
		wait_window(d);
		@(negedge sys_clk);
		hold_reset();
		check_reset_blank("mid-scan reset blank");
		read_and_check(ADDR_VALUE, 32'h0, "default value");
		read_and_check(ADDR_DIGIT_EN, 32'hFF, "default digit_en");
		read_and_check(ADDR_DP_EN, 32'h0, "default dp_en");
		// defaults light every digit with a plain zero
		wait_window(d);
		exp.seg = 8'hC0;
		exp.sel = ~(8'(1) << d);
		check_glyph($sformatf("default digit %0d", d), exp, panel_drive());
	endtask

	initial begin
		sys_rst_n = 1'b0;
		reg_wr    = 1'b0;
		reg_rd    = 1'b0;
		reg_addr  = ADDR_VALUE;
		reg_wdata = '0;
		// address-tagged fill shows up if the file is short
		for (int i = 0; i < NUM_CASES * CASE_WORDS; i++) begin
			case_mem[i] = {16'hA5A5, 16'(i)};
		end
		$readmemh("sim/seg_display_cases.txt", case_mem);
		check_cases_loaded();
		hold_reset();
		check_reset_blank("power-on blank");
		test_readback();
		for (int c = 0; c < NUM_CASES; c++) begin
			run_case(c);
		end
		test_mid_reset();
		$display("Testbench passed");
		$finish;
	end

	// watchdog sized from the case count
	initial begin
		#(TIMEOUT);
		$display("timeout after %0d time units, the scan or a register access hung", TIMEOUT);
		abort_run();
	end

endmodule

// File: sim/seg_display_cases.txt
// value digit_en dp_en, then glyph codes for digits 0..7 (all hex)
// digit 0 is leftmost and shows nibble 7; codes include the decimal point
// full hex range
01234567 FF 00 C0 F9 A4 B0 99 92 82 F8
89ABCDEF FF 00 80 90 88 83 A7 A1 84 8E
00000000 FF FF 40 40 40 40 40 40 40 40
FFFFFFFF FF 00 8E 8E 8E 8E 8E 8E 8E 8E
76543210 FF 01 78 82 92 99 B0 A4 F9 C0
FEDCBA98 FF 80 8E 84 A1 A7 83 88 90 00
// partial enables and mixed decimal points
12345678 0F 00 F9 A4 B0 99 92 82 F8 80
DEADBEEF F0 0F 21 04 08 21 83 84 84 8E
CAFEF00D AA 55 27 88 0E 84 0E C0 40 A1
55AA55AA 55 AA 92 12 88 08 92 12 88 08
00000001 01 00 C0 C0 C0 C0 C0 C0 C0 F9
80000000 80 00 80 C0 C0 C0 C0 C0 C0 C0
13579BDF FF 3C F9 B0 12 78 10 03 A1 8E
02468ACE FF C3 40 24 99 82 80 88 27 04
00C0FFEE 3C 00 C0 C0 A7 C0 8E 8E 84 84
BAADF00D FF 00 83 88 88 A1 8E C0 C0 A1
31415926 FF 02 B0 79 99 F9 92 90 A4 82
27182818 FF 40 A4 F8 F9 80 A4 80 79 80
// nothing selected
00000000 00 00 C0 C0 C0 C0 C0 C0 C0 C0
FFFFFFFF 00 FF 0E 0E 0E 0E 0E 0E 0E 0E
// assorted patterns
0F0F0F0F 0F F0 C0 8E C0 8E 40 0E 40 0E
9E3779B9 FF 00 90 84 B0 F8 F8 90 83 90
600DCAFE 81 18 82 C0 C0 21 27 88 8E 84
ABCDEF01 7E 81 08 83 A7 A1 84 8E C0 79
44444444 FF 00 99 99 99 99 99 99 99 99
11111111 24 24 F9 F9 79 F9 F9 79 F9 F9
8BADF00D FF 00 80 83 88 A1 8E C0 C0 A1
1234ABCD FF FF 79 24 30 19 08 03 27 21

// File: compile.f
common/seg_display_pkg.sv
seg_display/scan_tick.sv
seg_display/seg_scanner.sv
hdl/disp_regs.sv
hdl/seg_display_top.sv
sim/seg_display_assertions.sv
sim/tb_seg_display.sv

// File: run_sim.sh
#!/bin/sh
# build and run the seven-segment display testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -j 0 \
	--top-module tb_seg_display \
	-Mdir "$BUILD_DIR" \
	-f compile.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vtb_seg_display" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi
